//--- Makefile
# Verilator build and run for the L2 tag lookup
VERILATOR ?= verilator
TOP       ?= l2_tag_tb
FILELIST  ?= l2_tag.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?=

# sources come from the file list, so the binary tracks every listed file
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(BIN)
	./$(BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/l2_sync_ram.sv
//##########################################################
// single port, registered read, no reset on contents
// read during write to the same address returns old data
//##########################################################
`timescale 1ns/1ps

module l2_sync_ram #(
    parameter int  DEPTH     = l2_tag_pkg::SETS,
    parameter type payload_t = logic
) (
    input  logic               clk,
    input  l2_tag_pkg::index_t addr,
    input  logic               we,
    input  payload_t           wdata,
    output payload_t           rdata
);

    payload_t mem [DEPTH];   // contents undefined until first write

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];   // old data on a same-address write
    end

endmodule

//--- hdl/l2_tag_array.sv
//##########################################################
// stage 1: one read and one update write per clock
// read data is pre-update; stage 2 forwards the last write
//##########################################################
`timescale 1ns/1ps

module l2_tag_array #(
    parameter int SETS = l2_tag_pkg::SETS
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            req_valid,
    input  logic [l2_tag_pkg::ADDR_W-1:0]   req_addr,
    input  logic                            req_store,
    input  l2_tag_pkg::update_t             update,
    output l2_tag_pkg::req_t                s1_req,
    output l2_tag_pkg::set_state_t          set_state
);
    import l2_tag_pkg::*;

    index_t          req_index;
    tag_t            req_tag;
    logic [WAYS-1:0] valid_arr [SETS];   // valid bits, cleared by reset
    plru_t           plru_arr  [SETS];
    logic [WAYS-1:0] bank_sel  [SETS];   // which copy holds the live entry, per way
    logic [WAYS-1:0] rd_sel;
    logic [WAYS-1:0] rd_sel_q;
    logic [WAYS-1:0] wr_bank;
    logic [WAYS-1:0] way_we;
    logic [WAYS-1:0] valid_rd_q;
    plru_t           plru_rd_q;
    logic            bank_we   [WAYS][2];
    index_t          bank_addr [WAYS][2];
    tag_t            tag_rd    [WAYS][2];
    logic            dirty_rd  [WAYS][2];

    assign req_index = req_addr[OFFSET_W +: INDEX_W];
    assign req_tag   = req_addr[ADDR_W-1 -: TAG_W];

    // read from the copy holding the live entry, write the other one
    assign rd_sel  = bank_sel[req_index];
    assign wr_bank = ~rd_sel;

    // per-way strobes; tag and dirty are always written as a pair
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        assign way_we[w] = update.en && (update.tag_we || update.dirty_we)
                           && (update.way == way_t'(w));

        for (genvar b = 0; b < 2; b++) begin : g_bank
            assign bank_we[w][b]   = way_we[w] && (wr_bank[w] == 1'(b));
            assign bank_addr[w][b] = bank_we[w][b] ? update.index : req_index;

            l2_sync_ram #(.DEPTH(SETS), .payload_t(tag_t)) u_tag_ram (
                .clk   (clk),
                .addr  (bank_addr[w][b]),
                .we    (bank_we[w][b]),
                .wdata (update.tag),
                .rdata (tag_rd[w][b])
            );

            l2_sync_ram #(.DEPTH(SETS), .payload_t(logic)) u_dirty_ram (
                .clk   (clk),
                .addr  (bank_addr[w][b]),
                .we    (bank_we[w][b]),
                .wdata (update.dirty),
                .rdata (dirty_rd[w][b])
            );
        end
    end

    // valid, plru and bank select live in flops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                valid_arr[s] <= '0;
                plru_arr[s]  <= '0;
                bank_sel[s]  <= '0;
            end
        end else if (update.en) begin
            plru_arr[update.index] <= update.plru;
            if (update.valid_set)
                valid_arr[update.index][update.way] <= 1'b1;
            for (int w = 0; w < WAYS; w++) begin
                if (way_we[w])
                    bank_sel[update.index][w] <= wr_bank[w];   // live copy moves
            end
        end
    end

    // request and flop reads line up with the RAM output
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_req     <= '0;
            rd_sel_q   <= '0;
            valid_rd_q <= '0;
            plru_rd_q  <= '0;
        end else begin
            s1_req.valid <= req_valid;
            s1_req.store <= req_store;
            s1_req.tag   <= req_tag;
            s1_req.index <= req_index;
            rd_sel_q     <= rd_sel;
            valid_rd_q   <= valid_arr[req_index];   // pre-update value
            plru_rd_q    <= plru_arr[req_index];
        end
    end

    always_comb begin
        set_state.valid = valid_rd_q;
        set_state.plru  = plru_rd_q;
        for (int w = 0; w < WAYS; w++) begin
            set_state.tag[w]   = tag_rd[w][rd_sel_q[w]];
            set_state.dirty[w] = dirty_rd[w][rd_sel_q[w]];
        end
    end

endmodule

//--- hdl/l2_tag_compare.sv
//##########################################################
// stage 2: hit/miss, victim choice, update build
// only the previous update is forwarded, older ones are in RAM
//##########################################################
`timescale 1ns/1ps

module l2_tag_compare (
    input  logic                   clk,
    input  logic                   rst_n,
    input  l2_tag_pkg::req_t       s1_req,
    input  l2_tag_pkg::set_state_t set_state,
    output l2_tag_pkg::update_t    update,
    output l2_tag_pkg::resp_t      resp
);
    import l2_tag_pkg::*;

    update_t         upd_q;       // write that landed with this read
    set_state_t      st;          // set state after forwarding
    logic            fwd;
    logic [WAYS-1:0] hit_vec;
    logic            hit;
    logic            all_valid;
    way_t            hit_way;
    way_t            inv_way;
    way_t            victim_way;
    way_t            sel_way;
    resp_t           resp_d;

    assign fwd = upd_q.en && (upd_q.index == s1_req.index);

    // patch stale read data with the write from the same edge
    always_comb begin
        st = set_state;
        if (fwd) begin
            st.plru = upd_q.plru;
            if (upd_q.tag_we)
                st.tag[upd_q.way] = upd_q.tag;
            if (upd_q.dirty_we)
                st.dirty[upd_q.way] = upd_q.dirty;
            if (upd_q.valid_set)
                st.valid[upd_q.way] = 1'b1;
        end
    end

    // tag compare, valid ways only
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = st.valid[w] && (st.tag[w] == s1_req.tag);
            if (hit_vec[w])
                hit_way = way_t'(w);   // at most one way can match
        end
    end

    assign hit       = |hit_vec;
    assign all_valid = &st.valid;

    // lowest invalid way first
    always_comb begin
        inv_way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!st.valid[w])
                inv_way = way_t'(w);
        end
    end

    assign victim_way = all_valid ? plru_victim(st.plru) : inv_way;
    assign sel_way    = hit ? hit_way : victim_way;

    // write-back for this request; on a hit the tag is rewritten unchanged
    always_comb begin
        update.en        = s1_req.valid;
        update.index     = s1_req.index;
        update.way       = sel_way;
        update.tag_we    = !hit;
        update.tag       = s1_req.tag;
        update.dirty_we  = !hit || s1_req.store;
        update.dirty     = s1_req.store;            // clean fill unless store
        update.valid_set = !hit;
        update.plru      = plru_touch(st.plru, sel_way);
    end

    // victim fields only mean something on a miss
    always_comb begin
        resp_d.valid        = s1_req.valid;
        resp_d.hit          = hit;
        resp_d.way          = sel_way;
        resp_d.victim_valid = !hit && st.valid[victim_way];
        resp_d.victim_dirty = !hit && st.valid[victim_way] && st.dirty[victim_way];
        resp_d.victim_tag   = hit ? '0 : st.tag[victim_way];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            upd_q <= '0;
            resp  <= '0;
        end else begin
            upd_q <= update;   // lands in the array on this edge
            resp  <= resp_d;
        end
    end

endmodule

//--- hdl/l2_tag_lookup.sv
//##########################################################
// 2-cycle tag lookup, one request per clock, no stall
// SETS must match 1 << INDEX_W of the package
//##########################################################
`timescale 1ns/1ps

module l2_tag_lookup #(
    parameter int SETS = 512
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            req_valid,   // one-cycle strobe
    input  logic [l2_tag_pkg::ADDR_W-1:0]   req_addr,
    input  logic                            req_store,
    output l2_tag_pkg::resp_t               resp         // valid two clocks later
);
    import l2_tag_pkg::*;

    req_t       s1_req;
    set_state_t set_state;
    update_t    update;      // compare -> array, same cycle

    // stage 1: read the set, apply the update write
    l2_tag_array #(
        .SETS (SETS)
    ) u_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .req_store (req_store),
        .update    (update),
        .s1_req    (s1_req),
        .set_state (set_state)
    );

    // stage 2: forward, compare, pick victim
    l2_tag_compare u_compare (
        .clk       (clk),
        .rst_n     (rst_n),
        .s1_req    (s1_req),
        .set_state (set_state),
        .update    (update),
        .resp      (resp)
    );

endmodule

//--- hdl/l2_tag_pkg.sv
//##########################################################
// PLRU helpers assume exactly 4 ways (3-bit tree)
// SETS must stay 1 << INDEX_W; offset bits are never used
//##########################################################
package l2_tag_pkg;

    localparam int ADDR_W   = 32;
    localparam int OFFSET_W = 5;                            // 32-byte line, ignored
    localparam int INDEX_W  = 9;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;  // 18
    localparam int WAYS     = 4;                            // tied to plru_t
    localparam int SETS     = 1 << INDEX_W;

    typedef logic [TAG_W-1:0]         tag_t;
    typedef logic [INDEX_W-1:0]       index_t;
    typedef logic [$clog2(WAYS)-1:0]  way_t;
    typedef logic [2:0]               plru_t;   // {b2, b1, b0}, b0 is root

    // request as it travels down the pipe
    typedef struct packed {
        logic   valid;
        logic   store;
        tag_t   tag;
        index_t index;
    } req_t;

    // one set as read out of the array
    typedef struct packed {
        tag_t [WAYS-1:0] tag;
        logic [WAYS-1:0] valid;
        logic [WAYS-1:0] dirty;
        plru_t           plru;
    } set_state_t;

    // write-back into the array, one way per request
    typedef struct packed {
        logic   en;
        index_t index;
        way_t   way;
        logic   tag_we;
        tag_t   tag;
        logic   dirty_we;
        logic   dirty;
        logic   valid_set;
        plru_t  plru;         // always written when en
    } update_t;

    typedef struct packed {
        logic   valid;
        logic   hit;
        way_t   way;          // hit way, or allocated way on a miss
        logic   victim_valid;
        logic   victim_dirty;
        tag_t   victim_tag;
    } resp_t;

    // follow the tree to the least recently used way
    function automatic way_t plru_victim(plru_t p);
        way_t w;
        if (!p[0])
            w = p[1] ? 2'd1 : 2'd0;   // left pair
        else
            w = p[2] ? 2'd3 : 2'd2;   // right pair
        return w;
    endfunction

    // point the tree away from the way just used
    function automatic plru_t plru_touch(plru_t p, way_t w);
        plru_t n;
        n = p;
        case (w)
            2'd0: n[1:0] = 2'b11;
            2'd1: n[1:0] = 2'b01;
            2'd2: begin
                n[2] = 1'b1;
                n[0] = 1'b0;
            end
            default: begin
                n[2] = 1'b0;
                n[0] = 1'b0;
            end
        endcase
        return n;
    endfunction

endpackage

//--- l2_tag.f
hdl/l2_tag_pkg.sv
hdl/l2_sync_ram.sv
hdl/l2_tag_array.sv
hdl/l2_tag_compare.sv
hdl/l2_tag_lookup.sv
testbench/l2_tag_sva.sv
testbench/l2_tag_tb.sv

//--- testbench/l2_tag_sva.sv
//##########################################################
// latency and reset checks, bound into l2_tag_lookup
// assumes no reset is applied while requests are in flight
//##########################################################
`timescale 1ns/1ps

module l2_tag_sva (
    input logic                clk,
    input logic                rst_n,
    input logic                req_valid,
    input l2_tag_pkg::resp_t   resp,
    input l2_tag_pkg::update_t update    // internal compare -> array bus
);

    // every strobe is answered two edges later
    property p_latency;
        @(posedge clk) disable iff (!rst_n)
            req_valid |-> ##2 resp.valid;
    endproperty

    // an answer needs a strobe two edges back
    property p_no_orphan;
        @(posedge clk) disable iff (!rst_n)
            resp.valid |-> $past(req_valid, 2);
    endproperty

    // pipe stays empty while held in reset
    property p_reset_quiet;
        @(posedge clk) !rst_n |-> !resp.valid && !update.en;
    endproperty

    // first two edges after release cannot carry a response
    property p_release_quiet;
        @(posedge clk) $rose(rst_n) |-> !resp.valid ##1 !resp.valid;
    endproperty

    a_latency: assert property (p_latency)
        else $error("resp.valid missing two cycles after req_valid");
    a_no_orphan: assert property (p_no_orphan)
        else $error("resp.valid without a request two cycles earlier");
    a_reset_quiet: assert property (p_reset_quiet)
        else $error("resp.valid or update.en high during reset");
    a_release_quiet: assert property (p_release_quiet)
        else $error("resp.valid high right after reset release");

endmodule

bind l2_tag_lookup l2_tag_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .resp      (resp),
    .update    (update)
);

//--- testbench/l2_tag_tb.sv
//##########################################################
// reference model tracks tags, valid, dirty, PLRU per set
// victim_tag is compared only when the victim way was valid
//##########################################################
`timescale 1ns/1ps

module l2_tag_tb;
    import l2_tag_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    logic [31:0] req_addr;
    logic        req_store;
    resp_t       resp;

    tag_t        m_tag   [SETS][WAYS];   // model contents
    bit          m_valid [SETS][WAYS];
    bit          m_dirty [SETS][WAYS];
    plru_t       m_plru  [SETS];
    resp_t       exp_q   [$];            // expected answers, oldest first
    string       name_q  [$];
    string       test_name;
    int          errors;
    int          checks;
    logic [31:0] seed;
    tag_t        pool [8];               // few tags, so sets overflow often
    index_t      set_pool [4];

    l2_tag_lookup #(.SETS(SETS)) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .req_store (req_store),
        .resp      (resp)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // root bit picks the pair, the pair bit picks the way in it
    function automatic way_t tree_pick(input plru_t p);
        return {p[0], p[0] ? p[2] : p[1]};
    endfunction

    // point the tree at the other half and the other way of the pair
    function automatic plru_t tree_mark(input plru_t p, input way_t w);
        plru_t n;
        n = p;
        if (!w[1]) begin
            n[0] = 1'b1;
            n[1] = (w == 2'd0);
        end else begin
            n[0] = 1'b0;
            n[2] = (w == 2'd2);
        end
        return n;
    endfunction

    // one access against the model, expected answer goes on the queue
    task automatic model_access(input tag_t tag, input index_t idx, input logic store);
        resp_t e;
        way_t  w;
        bit    hit;
        e       = '0;
        e.valid = 1'b1;
        hit     = 1'b0;
        w       = '0;
        for (int i = 0; i < WAYS; i++) begin
            if (m_valid[idx][i] && m_tag[idx][i] == tag) begin
                hit = 1'b1;
                w   = way_t'(i);
            end
        end
        if (!hit) begin
            w = tree_pick(m_plru[idx]);       // all valid case
            for (int i = WAYS - 1; i >= 0; i--) begin
                if (!m_valid[idx][i])
                    w = way_t'(i);             // lowest invalid wins
            end
            e.victim_valid   = m_valid[idx][w];
            e.victim_dirty   = m_valid[idx][w] && m_dirty[idx][w];
            e.victim_tag     = m_tag[idx][w];
            m_tag[idx][w]    = tag;
            m_valid[idx][w]  = 1'b1;
            m_dirty[idx][w]  = store;
        end else if (store) begin
            m_dirty[idx][w] = 1'b1;
        end
        e.hit       = hit;
        e.way       = w;
        m_plru[idx] = tree_mark(m_plru[idx], w);
        exp_q.push_back(e);
        name_q.push_back(test_name);
    endtask

    task automatic send(input tag_t tag, input index_t idx, input logic store);
        @(negedge clk);
        req_valid = 1'b1;
        req_addr  = {tag, idx, seed[4:0]};   // offset bits are noise
        req_store = store;
        model_access(tag, idx, store);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            req_valid = 1'b0;
        end
    endtask

    // wait until every queued answer came back, bounded
    task automatic drain();
        int t;
        t = 0;
        idle(1);
        while (exp_q.size() != 0 && t < 20) begin
            @(negedge clk);
            t++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("timeout: %0d responses never arrived in %s", exp_q.size(), test_name);
            exp_q.delete();
            name_q.delete();
        end
    endtask

    task automatic check_field(input string test, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[FAIL] %s %s: expected %0h actual %0h", test, field, exp, act);
        end
    endtask

    // resp is stable at the falling edge
    always @(negedge clk) begin : check_resp
        resp_t e;
        string n;
        if (resp.valid === 1'b1) begin
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("response arrived with no request outstanding");
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                n = name_q.pop_front();
                check_field(n, "hit", 32'(e.hit), 32'(resp.hit));
                check_field(n, "way", 32'(e.way), 32'(resp.way));
                check_field(n, "victim_valid", 32'(e.victim_valid), 32'(resp.victim_valid));
                check_field(n, "victim_dirty", 32'(e.victim_dirty), 32'(resp.victim_dirty));
                if (e.victim_valid)
                    check_field(n, "victim_tag", 32'(e.victim_tag), 32'(resp.victim_tag));
            end
        end
    end

    initial begin : stimulus
        int sent;
        clk       = 1'b0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_addr  = '0;
        req_store = 1'b0;
        errors    = 0;
        checks    = 0;
        seed      = 32'd88;
        test_name = "reset";
        pool      = '{18'h00A11, 18'h1B2C3, 18'h0F00F, 18'h3FFFF,
                      18'h12345, 18'h00000, 18'h2AAAA, 18'h15555};
        set_pool  = '{9'd0, 9'd3, 9'd100, 9'd511};
        for (int s = 0; s < SETS; s++) begin
            m_plru[s] = '0;
            for (int w = 0; w < WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        idle(5);   // nothing may answer yet

        test_name = "cold_miss";
        for (int i = 0; i < 4; i++)
            send(pool[i], 9'd3, 1'b0);    // ways 0..3 in order
        drain();

        test_name = "hit";
        send(pool[0], 9'd3, 1'b1);        // store marks way 0 dirty
        send(pool[2], 9'd3, 1'b0);
        drain();

        test_name = "plru_evict";
        for (int i = 4; i < 8; i++)
            send(pool[i], 9'd3, 1'b0);    // four misses sweep all ways
        drain();

        test_name = "bypass";
        send(pool[0], 9'd100, 1'b0);
        send(pool[0], 9'd100, 1'b0);      // sees the fill one cycle old
        send(pool[1], 9'd100, 1'b1);
        send(pool[1], 9'd100, 1'b0);
        send(pool[2], 9'd100, 1'b0);
        send(pool[3], 9'd100, 1'b0);
        send(pool[4], 9'd100, 1'b0);      // back-to-back evictions
        send(pool[5], 9'd100, 1'b0);
        send(pool[5], 9'd101, 1'b0);      // neighbour set, no forward
        send(pool[5], 9'd100, 1'b1);
        drain();

        test_name = "random";
        sent = 0;
        while (sent < 2000) begin
            seed = lcg_next(seed);
            if (seed[31:30] == 2'd0) begin
                idle(1);
            end else begin
                send(pool[seed[22:20]], set_pool[seed[25:24]], seed[27]);
                sent++;
            end
        end
        drain();
        idle(3);

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule
